// ==== rab_read_top.f ====
src/rab_pkg.sv
src/axi_buffer_rab.sv
src/rab_slice_table.sv
src/axi4_ar_sender.sv
src/axi4_r_sender.sv
src/rab_read_top.sv
verification/rab_read_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rab_read_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module rab_read_tb -f rab_read_top.f -o rab_read_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/rab_read_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// ==== verification/rab_read_tb.sv ====
`timescale 1ns/1ps

module rab_read_tb;

  // about 40 transactions of under 100 cycles each
  localparam int TIMEOUT_CYCLES = 4000;

  typedef struct packed {
    rab_pkg::id_t   id;
    rab_pkg::addr_t addr;
    rab_pkg::len_t  len;
    rab_pkg::user_t user;
  } ar_rec_t;

  // chk_data is clear for the bridge's own beats, whose data carries no meaning
  typedef struct packed {
    rab_pkg::id_t   id;
    rab_pkg::data_t data;
    rab_pkg::resp_t resp;
    logic           last;
    rab_pkg::user_t user;
    logic           chk_data;
  } beat_t;

  logic              axi4_aclk;
  logic              axi4_arstn;
  rab_pkg::id_t      s_axi4_arid;
  rab_pkg::addr_t    s_axi4_araddr;
  rab_pkg::len_t     s_axi4_arlen;
  rab_pkg::user_t    s_axi4_aruser;
  logic              s_axi4_arvalid;
  logic              s_axi4_arready;
  rab_pkg::id_t      s_axi4_rid;
  rab_pkg::resp_t    s_axi4_rresp;
  rab_pkg::data_t    s_axi4_rdata;
  logic              s_axi4_rlast;
  logic              s_axi4_rvalid;
  rab_pkg::user_t    s_axi4_ruser;
  logic              s_axi4_rready;
  rab_pkg::id_t      m_axi4_arid;
  rab_pkg::addr_t    m_axi4_araddr;
  rab_pkg::len_t     m_axi4_arlen;
  rab_pkg::user_t    m_axi4_aruser;
  logic              m_axi4_arvalid;
  logic              m_axi4_arready;
  rab_pkg::id_t      m_axi4_rid;
  rab_pkg::resp_t    m_axi4_rresp;
  rab_pkg::data_t    m_axi4_rdata;
  logic              m_axi4_rlast;
  logic              m_axi4_rvalid;
  rab_pkg::user_t    m_axi4_ruser;
  logic              m_axi4_rready;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  rab_pkg::wb_addr_t wb_adr_i;
  rab_pkg::data_t    wb_dat_i;
  rab_pkg::data_t    wb_dat_o;
  logic              wb_ack_o;

  // slice setup as written over Wishbone, also the reference for lookups
  rab_pkg::addr_t cfg_start  [rab_pkg::NUM_SLICES];
  rab_pkg::addr_t cfg_end    [rab_pkg::NUM_SLICES];
  rab_pkg::addr_t cfg_offset [rab_pkg::NUM_SLICES];
  rab_pkg::data_t cfg_flags  [rab_pkg::NUM_SLICES];
  rab_pkg::addr_t bp_addr    [6];

  beat_t   exp_q [$];
  ar_rec_t far_q [$];
  ar_rec_t mem_q [$];
  ar_rec_t cur_burst;
  ar_rec_t mar_rec;
  bit      mar_seen;
  bit      mbeat_taken;
  bit      busy;
  int      beat_idx;
  bit      bp_en;
  int      errors;
  int      checks;
  int      cycles;

  rab_read_top u_rab_read_top (.*);

  initial begin
    axi4_aclk = 1'b0;
    forever #10 axi4_aclk = ~axi4_aclk;
  end

  function automatic void compare_field(input string name, input logic [31:0] got,
                                        input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, want);
    end
  endfunction

  // lowest enabled slice whose range holds the address decides
  function automatic void translate(input rab_pkg::addr_t addr, output bit hit,
                                    output bit allow, output rab_pkg::addr_t phys);
    hit   = 1'b0;
    allow = 1'b0;
    phys  = '0;
    for (int i = 0; i < rab_pkg::NUM_SLICES; i++) begin
      if (!hit && cfg_flags[i][rab_pkg::FLAG_EN] && addr >= cfg_start[i] &&
          addr <= cfg_end[i]) begin
        hit   = 1'b1;
        allow = cfg_flags[i][rab_pkg::FLAG_RD];
        phys  = addr - cfg_start[i] + cfg_offset[i];
      end
    end
  endfunction

  function automatic void expect_request(input rab_pkg::id_t id, input rab_pkg::addr_t addr,
                                         input rab_pkg::len_t len, input rab_pkg::user_t user);
    bit             hit;
    bit             allow;
    rab_pkg::addr_t phys;
    rab_pkg::resp_t resp;
    translate(addr, hit, allow, phys);
    if (hit && allow) begin
      far_q.push_back(ar_rec_t'{id, phys, len, user});
      for (int i = 0; i <= int'(len); i++) begin
        exp_q.push_back(beat_t'{id, phys + rab_pkg::addr_t'(i), rab_pkg::RESP_OKAY,
                                (i == int'(len)), user, 1'b1});
      end
    end else begin
      resp = (hit && user[0]) ? rab_pkg::RESP_OKAY : rab_pkg::RESP_SLVERR;
      exp_q.push_back(beat_t'{id, 32'h0, resp, 1'b1, 4'h0, 1'b0});
    end
  endfunction

  function automatic void match_forward();
    ar_rec_t f;
    if (far_q.size() == 0) begin
      errors++;
      $display("Error: address %h reached the master side without a request for it",
               m_axi4_araddr);
    end else begin
      f = far_q.pop_front();
      compare_field("m_axi4_araddr", m_axi4_araddr, f.addr);
      compare_field("m_axi4_arid", 32'(m_axi4_arid), 32'(f.id));
      compare_field("m_axi4_arlen", 32'(m_axi4_arlen), 32'(f.len));
      compare_field("m_axi4_aruser", 32'(m_axi4_aruser), 32'(f.user));
    end
  endfunction

  // first waiting beat of the same id keeps the order per id
  function automatic void score_beat();
    int    idx;
    beat_t e;
    idx = -1;
    foreach (exp_q[i]) begin
      if (idx < 0 && exp_q[i].id == s_axi4_rid) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      errors++;
      $display("Error: a read beat with id %h arrived that no request was waiting for",
               s_axi4_rid);
    end else begin
      e = exp_q[idx];
      exp_q.delete(idx);
      compare_field("s_axi4_rresp", 32'(s_axi4_rresp), 32'(e.resp));
      compare_field("s_axi4_rlast", 32'(s_axi4_rlast), 32'(e.last));
      compare_field("s_axi4_ruser", 32'(s_axi4_ruser), 32'(e.user));
      if (e.chk_data) begin
        compare_field("s_axi4_rdata", s_axi4_rdata, e.data);
      end
    end
  endfunction

  // sampled on the rising edge, before any register of the DUT moves
  always @(posedge axi4_aclk) begin
    mar_seen    = axi4_arstn && m_axi4_arvalid && m_axi4_arready;
    mbeat_taken = axi4_arstn && m_axi4_rvalid && m_axi4_rready;
    mar_rec     = ar_rec_t'{m_axi4_arid, m_axi4_araddr, m_axi4_arlen, m_axi4_aruser};
    if (axi4_arstn) begin
      if (s_axi4_arvalid && s_axi4_arready) begin
        expect_request(s_axi4_arid, s_axi4_araddr, s_axi4_arlen, s_axi4_aruser);
      end
      if (mar_seen) begin
        match_forward();
      end
      if (s_axi4_rvalid && s_axi4_rready) begin
        score_beat();
      end
    end
  end

  // master-side memory: arlen+1 beats of address plus beat index, in request order
  always @(negedge axi4_aclk) begin
    if (mar_seen) begin
      mem_q.push_back(mar_rec);
    end
    if (mbeat_taken) begin
      if (beat_idx == int'(cur_burst.len)) begin
        busy = 1'b0;
      end else begin
        beat_idx++;
      end
    end
    if (!busy && mem_q.size() != 0) begin
      cur_burst = mem_q.pop_front();
      busy      = 1'b1;
      beat_idx  = 0;
    end
    m_axi4_rvalid  = busy;
    m_axi4_rid     = cur_burst.id;
    m_axi4_rdata   = cur_burst.addr + rab_pkg::data_t'(beat_idx);
    m_axi4_rlast   = busy && (beat_idx == int'(cur_burst.len));
    m_axi4_ruser   = cur_burst.user;
    m_axi4_rresp   = rab_pkg::RESP_OKAY;
    s_axi4_rready  = bp_en ? 1'($urandom_range(0, 1)) : 1'b1;
    m_axi4_arready = bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  a_ack_one_cycle: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    wb_ack_o |=> !wb_ack_o)
    else begin
      errors++;
      $display("Error: wb_ack_o stayed high for more than one cycle");
    end

  a_ack_requested: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else begin
      errors++;
      $display("Error: wb_ack_o rose without a Wishbone request");
    end

  a_r_held: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (s_axi4_rvalid && !s_axi4_rready) |=>
      (s_axi4_rvalid && $stable(s_axi4_rid) && $stable(s_axi4_rresp) && $stable(s_axi4_rlast)))
    else begin
      errors++;
      $display("Error: a read beat changed or vanished before s_axi4_rready took it");
    end

  a_no_hidden_take: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    m_axi4_rready |-> s_axi4_rready)
    else begin
      errors++;
      $display("Error: m_axi4_rready was high while s_axi4_rready was low");
    end

  a_ar_held: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (m_axi4_arvalid && !m_axi4_arready) |=> (m_axi4_arvalid && $stable(m_axi4_araddr)))
    else begin
      errors++;
      $display("Error: the forwarded AR changed or vanished before m_axi4_arready");
    end

  function automatic rab_pkg::wb_addr_t reg_addr(input int s, input int r);
    return rab_pkg::wb_addr_t'(16 * s + 4 * r);
  endfunction

  function automatic rab_pkg::data_t slice_reg(input int s, input int r);
    case (r)
      rab_pkg::REG_START:  return cfg_start[s];
      rab_pkg::REG_END:    return cfg_end[s];
      rab_pkg::REG_OFFSET: return cfg_offset[s];
      default:             return cfg_flags[s];
    endcase
  endfunction

  function automatic void idle_after_reset();
    compare_field("s_axi4_arready", 32'(s_axi4_arready), 32'h0);
    compare_field("m_axi4_arvalid", 32'(m_axi4_arvalid), 32'h0);
    compare_field("s_axi4_rvalid", 32'(s_axi4_rvalid), 32'h0);
    compare_field("wb_ack_o", 32'(wb_ack_o), 32'h0);
  endfunction

  task automatic wb_xfer(input bit we, input rab_pkg::wb_addr_t adr, input rab_pkg::data_t dat,
                         output rab_pkg::data_t rdat);
    @(negedge axi4_aclk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do @(posedge axi4_aclk); while (!wb_ack_o);
    rdat = wb_dat_o;
    @(negedge axi4_aclk);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic configure_slices();
    rab_pkg::data_t rdat;
    for (int s = 0; s < rab_pkg::NUM_SLICES; s++) begin
      for (int r = 0; r < 4; r++) begin
        wb_xfer(1'b1, reg_addr(s, r), slice_reg(s, r), rdat);
      end
    end
    // unaligned write lands nowhere
    wb_xfer(1'b1, 6'h01, 32'hdead_beef, rdat);
    for (int s = 0; s < rab_pkg::NUM_SLICES; s++) begin
      for (int r = 0; r < 4; r++) begin
        wb_xfer(1'b0, reg_addr(s, r), '0, rdat);
        compare_field("wb_dat_o", rdat, slice_reg(s, r));
      end
    end
    wb_xfer(1'b0, 6'h05, '0, rdat);
    compare_field("wb_dat_o", rdat, 32'h0);
  endtask

  task automatic issue_read(input rab_pkg::id_t id, input rab_pkg::addr_t addr,
                            input rab_pkg::len_t len, input rab_pkg::user_t user);
    @(negedge axi4_aclk);
    s_axi4_arid    = id;
    s_axi4_araddr  = addr;
    s_axi4_arlen   = len;
    s_axi4_aruser  = user;
    s_axi4_arvalid = 1'b1;
    do @(posedge axi4_aclk); while (!s_axi4_arready);
    @(negedge axi4_aclk);
    s_axi4_arvalid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || far_q.size() != 0) begin
      @(posedge axi4_aclk);
    end
  endtask

  // forwarded requests use ids 0-7 and dropped ones 8-15, so each id sees one path
  task automatic mixed_traffic();
    rab_pkg::addr_t addr;
    rab_pkg::addr_t phys;
    bit             hit;
    bit             allow;
    bp_en = 1'b1;
    for (int i = 0; i < 24; i++) begin
      addr = bp_addr[$urandom_range(0, 5)];
      translate(addr, hit, allow, phys);
      issue_read({~(hit & allow), 3'(i)}, addr, 8'($urandom_range(0, 3)),
                 4'($urandom_range(0, 1)));
    end
    wait_drain();
    bp_en = 1'b0;
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge axi4_aclk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(32'h4aac));
    errors         = 0;
    checks         = 0;
    bp_en          = 1'b0;
    axi4_arstn     = 1'b0;
    s_axi4_arid    = '0;
    s_axi4_araddr  = '0;
    s_axi4_arlen   = '0;
    s_axi4_aruser  = '0;
    s_axi4_arvalid = 1'b0;
    s_axi4_rready  = 1'b1;
    m_axi4_arready = 1'b1;
    m_axi4_rid     = '0;
    m_axi4_rresp   = '0;
    m_axi4_rdata   = '0;
    m_axi4_rlast   = 1'b0;
    m_axi4_rvalid  = 1'b0;
    m_axi4_ruser   = '0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    cur_burst      = '0;
    // slice 2 overlaps the top of slice 0, slice 1 lacks read permission
    cfg_start  = '{32'h1000_0000, 32'h2000_0000, 32'h1000_0800, 32'h3000_0000};
    cfg_end    = '{32'h1000_0fff, 32'h2000_ffff, 32'h1000_1fff, 32'h3000_00ff};
    cfg_offset = '{32'h8000_0000, 32'h0000_0000, 32'h4000_0000, 32'h0000_5000};
    cfg_flags  = '{32'h3, 32'h1, 32'h3, 32'h3};
    bp_addr    = '{32'h1000_0040, 32'h1000_1400, 32'h3000_0010, 32'h2000_0010,
                   32'h6000_0000, 32'h1000_0ff0};
    repeat (16) @(posedge axi4_aclk);
    @(negedge axi4_aclk);
    idle_after_reset();
    axi4_arstn = 1'b1;
    configure_slices();
    issue_read(4'h1, 32'h1000_0010, 8'd3, 4'h0);
    issue_read(4'h2, 32'h3000_0020, 8'd0, 4'h2);
    wait_drain();
    // misses, plain and prefetch
    issue_read(4'h3, 32'h5000_0000, 8'd2, 4'h0);
    issue_read(4'h4, 32'h0000_0100, 8'd0, 4'h1);
    wait_drain();
    issue_read(4'h5, 32'h2000_0100, 8'd1, 4'h1);
    issue_read(4'h6, 32'h2000_0200, 8'd0, 4'h0);
    issue_read(4'h7, 32'h1000_0900, 8'd1, 4'h0);
    issue_read(4'h8, 32'h1000_1800, 8'd0, 4'h0);
    wait_drain();
    mixed_traffic();
    repeat (4) @(posedge axi4_aclk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src/rab_read_top.sv ====
`timescale 1ns/1ps

module rab_read_top (
  input  logic              axi4_aclk,
  input  logic              axi4_arstn,
  input  rab_pkg::id_t      s_axi4_arid,
  input  rab_pkg::addr_t    s_axi4_araddr,
  input  rab_pkg::len_t     s_axi4_arlen,
  input  rab_pkg::user_t    s_axi4_aruser,
  input  logic              s_axi4_arvalid,
  output logic              s_axi4_arready,
  output rab_pkg::id_t      s_axi4_rid,
  output rab_pkg::resp_t    s_axi4_rresp,
  output rab_pkg::data_t    s_axi4_rdata,
  output logic              s_axi4_rlast,
  output logic              s_axi4_rvalid,
  output rab_pkg::user_t    s_axi4_ruser,
  input  logic              s_axi4_rready,
  output rab_pkg::id_t      m_axi4_arid,
  output rab_pkg::addr_t    m_axi4_araddr,
  output rab_pkg::len_t     m_axi4_arlen,
  output rab_pkg::user_t    m_axi4_aruser,
  output logic              m_axi4_arvalid,
  input  logic              m_axi4_arready,
  input  rab_pkg::id_t      m_axi4_rid,
  input  rab_pkg::resp_t    m_axi4_rresp,
  input  rab_pkg::data_t    m_axi4_rdata,
  input  logic              m_axi4_rlast,
  input  logic              m_axi4_rvalid,
  input  rab_pkg::user_t    m_axi4_ruser,
  output logic              m_axi4_rready,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  rab_pkg::wb_addr_t wb_adr_i,
  input  rab_pkg::data_t    wb_dat_i,
  output rab_pkg::data_t    wb_dat_o,
  output logic              wb_ack_o
);

  rab_pkg::addr_t lookup_addr;
  rab_pkg::addr_t phys_addr;
  logic           tbl_hit;
  logic           tbl_allow;

  // drop record from the AR side to the R side
  logic           drop;
  logic           drop_done;
  rab_pkg::id_t   drop_id;
  logic           drop_prefetch;
  logic           drop_hit;

  rab_slice_table u_rab_slice_table (
    .axi4_aclk     (axi4_aclk),
    .axi4_arstn    (axi4_arstn),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .lookup_addr_i (lookup_addr),
    .hit_o         (tbl_hit),
    .allow_o       (tbl_allow),
    .phys_addr_o   (phys_addr)
  );

  axi4_ar_sender u_axi4_ar_sender (
    .axi4_aclk      (axi4_aclk),
    .axi4_arstn     (axi4_arstn),
    .s_axi4_arid    (s_axi4_arid),
    .s_axi4_araddr  (s_axi4_araddr),
    .s_axi4_arlen   (s_axi4_arlen),
    .s_axi4_aruser  (s_axi4_aruser),
    .s_axi4_arvalid (s_axi4_arvalid),
    .s_axi4_arready (s_axi4_arready),
    .m_axi4_arid    (m_axi4_arid),
    .m_axi4_araddr  (m_axi4_araddr),
    .m_axi4_arlen   (m_axi4_arlen),
    .m_axi4_aruser  (m_axi4_aruser),
    .m_axi4_arvalid (m_axi4_arvalid),
    .m_axi4_arready (m_axi4_arready),
    .lookup_addr_o  (lookup_addr),
    .hit_i          (tbl_hit),
    .allow_i        (tbl_allow),
    .phys_addr_i    (phys_addr),
    .drop_o         (drop),
    .drop_id_o      (drop_id),
    .prefetch_o     (drop_prefetch),
    .hit_o          (drop_hit),
    .done_i         (drop_done)
  );

  axi4_r_sender u_axi4_r_sender (
    .axi4_aclk     (axi4_aclk),
    .axi4_arstn    (axi4_arstn),
    .drop_i        (drop),
    .done_o        (drop_done),
    .id_i          (drop_id),
    .prefetch_i    (drop_prefetch),
    .hit_i         (drop_hit),
    .s_axi4_rid    (s_axi4_rid),
    .s_axi4_rresp  (s_axi4_rresp),
    .s_axi4_rdata  (s_axi4_rdata),
    .s_axi4_rlast  (s_axi4_rlast),
    .s_axi4_rvalid (s_axi4_rvalid),
    .s_axi4_ruser  (s_axi4_ruser),
    .s_axi4_rready (s_axi4_rready),
    .m_axi4_rid    (m_axi4_rid),
    .m_axi4_rresp  (m_axi4_rresp),
    .m_axi4_rdata  (m_axi4_rdata),
    .m_axi4_rlast  (m_axi4_rlast),
    .m_axi4_rvalid (m_axi4_rvalid),
    .m_axi4_ruser  (m_axi4_ruser),
    .m_axi4_rready (m_axi4_rready)
  );

endmodule

// ==== src/axi4_r_sender.sv ====
`timescale 1ns/1ps

module axi4_r_sender (
  input  logic           axi4_aclk,
  input  logic           axi4_arstn,
  input  logic           drop_i,
  output logic           done_o,
  input  rab_pkg::id_t   id_i,
  input  logic           prefetch_i,
  input  logic           hit_i,
  output rab_pkg::id_t   s_axi4_rid,
  output rab_pkg::resp_t s_axi4_rresp,
  output rab_pkg::data_t s_axi4_rdata,
  output logic           s_axi4_rlast,
  output logic           s_axi4_rvalid,
  output rab_pkg::user_t s_axi4_ruser,
  input  logic           s_axi4_rready,
  input  rab_pkg::id_t   m_axi4_rid,
  input  rab_pkg::resp_t m_axi4_rresp,
  input  rab_pkg::data_t m_axi4_rdata,
  input  logic           m_axi4_rlast,
  input  logic           m_axi4_rvalid,
  input  rab_pkg::user_t m_axi4_ruser,
  output logic           m_axi4_rready
);

  logic           fifo_valid;
  logic           fifo_ready;
  logic           fifo_pop;
  rab_pkg::id_t   rec_id;
  logic           rec_prefetch;
  logic           rec_hit;
  logic           dropping;
  logic           beat_waiting;
  rab_pkg::resp_t drop_resp;

  axi_buffer_rab #(
    .DATA_WIDTH   (rab_pkg::DROP_REC_WIDTH),
    .BUFFER_DEPTH (rab_pkg::BUFFER_DEPTH)
  ) u_fifo (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     ({prefetch_i, hit_i, id_i}),
    .valid_i    (drop_i),
    .ready_o    (fifo_ready),
    .data_o     ({rec_prefetch, rec_hit, rec_id}),
    .valid_o    (fifo_valid),
    .ready_i    (fifo_pop)
  );

  // a full fifo holds off done and so stalls the AR side
  assign done_o   = drop_i & fifo_ready;
  assign fifo_pop = dropping & s_axi4_rready;

  // a master beat offered but not yet taken must not be replaced
  assign beat_waiting = m_axi4_rvalid & ~s_axi4_rready;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      dropping <= 1'b0;
    end else begin
      if (fifo_valid && !dropping && !beat_waiting) begin
        dropping <= 1'b1;
      end else if (fifo_pop) begin
        dropping <= 1'b0;
      end
    end
  end

  // only a prefetch that hit a slice is answered with OKAY
  assign drop_resp = (rec_prefetch && rec_hit) ? rab_pkg::RESP_OKAY : rab_pkg::RESP_SLVERR;

  assign s_axi4_rdata  = m_axi4_rdata;
  assign s_axi4_rid    = dropping ? rec_id : m_axi4_rid;
  assign s_axi4_rresp  = dropping ? drop_resp : m_axi4_rresp;
  assign s_axi4_rlast  = dropping | m_axi4_rlast;
  assign s_axi4_ruser  = dropping ? '0 : m_axi4_ruser;
  assign s_axi4_rvalid = dropping | m_axi4_rvalid;
  assign m_axi4_rready = ~dropping & s_axi4_rready;

  a_err_beat_held: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (dropping && !s_axi4_rready) |=>
      (dropping && s_axi4_rvalid && $stable(s_axi4_rid) && $stable(s_axi4_rresp)));

endmodule

// ==== src/axi4_ar_sender.sv ====
`timescale 1ns/1ps

module axi4_ar_sender (
  input  logic           axi4_aclk,
  input  logic           axi4_arstn,
  input  rab_pkg::id_t   s_axi4_arid,
  input  rab_pkg::addr_t s_axi4_araddr,
  input  rab_pkg::len_t  s_axi4_arlen,
  input  rab_pkg::user_t s_axi4_aruser,
  input  logic           s_axi4_arvalid,
  output logic           s_axi4_arready,
  output rab_pkg::id_t   m_axi4_arid,
  output rab_pkg::addr_t m_axi4_araddr,
  output rab_pkg::len_t  m_axi4_arlen,
  output rab_pkg::user_t m_axi4_aruser,
  output logic           m_axi4_arvalid,
  input  logic           m_axi4_arready,
  output rab_pkg::addr_t lookup_addr_o,
  input  logic           hit_i,
  input  logic           allow_i,
  input  rab_pkg::addr_t phys_addr_i,
  output logic           drop_o,
  output rab_pkg::id_t   drop_id_o,
  output logic           prefetch_o,
  output logic           hit_o,
  input  logic           done_i
);

  rab_pkg::ar_state_t state_q;
  rab_pkg::ar_state_t state_d;
  logic               arready_q;
  logic               accept;

  rab_pkg::id_t   id_q;
  rab_pkg::addr_t addr_q;
  rab_pkg::len_t  len_q;
  rab_pkg::user_t user_q;
  logic           hit_q;

  // the table sees the incoming address directly
  assign lookup_addr_o = s_axi4_araddr;

  assign accept         = s_axi4_arvalid & arready_q;
  assign s_axi4_arready = arready_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rab_pkg::AR_IDLE: begin
        if (accept) begin
          state_d = (hit_i && allow_i) ? rab_pkg::AR_FWD : rab_pkg::AR_DROP;
        end
      end
      rab_pkg::AR_FWD: begin
        if (m_axi4_arready) begin
          state_d = rab_pkg::AR_IDLE;
        end
      end
      rab_pkg::AR_DROP: begin
        if (done_i) begin
          state_d = rab_pkg::AR_IDLE;
        end
      end
      default: state_d = rab_pkg::AR_IDLE;
    endcase
  end

  // arready is registered so it stays low in the first cycle out of reset
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q   <= rab_pkg::AR_IDLE;
      arready_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      arready_q <= (state_d == rab_pkg::AR_IDLE);
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (accept) begin
      id_q   <= s_axi4_arid;
      addr_q <= phys_addr_i;
      len_q  <= s_axi4_arlen;
      user_q <= s_axi4_aruser;
      hit_q  <= hit_i;
    end
  end

  assign m_axi4_arvalid = (state_q == rab_pkg::AR_FWD);
  assign m_axi4_arid    = id_q;
  assign m_axi4_araddr  = addr_q;
  assign m_axi4_arlen   = len_q;
  assign m_axi4_aruser  = user_q;

  assign drop_o     = (state_q == rab_pkg::AR_DROP);
  assign drop_id_o  = id_q;
  assign prefetch_o = user_q[0];
  assign hit_o      = hit_q;

  // a forwarded request stays put until the master side takes it
  a_fwd_held: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (m_axi4_arvalid && !m_axi4_arready) |=>
      (m_axi4_arvalid && $stable(m_axi4_araddr) && $stable(m_axi4_arid)));

  // a drop record is held steady until the R side takes it
  a_drop_held: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (drop_o && !done_i) |=> (drop_o && $stable(drop_id_o) && $stable(prefetch_o)));

endmodule

// ==== src/rab_slice_table.sv ====
`timescale 1ns/1ps

module rab_slice_table (
  input  logic             axi4_aclk,
  input  logic             axi4_arstn,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  rab_pkg::wb_addr_t wb_adr_i,
  input  rab_pkg::data_t   wb_dat_i,
  output rab_pkg::data_t   wb_dat_o,
  output logic             wb_ack_o,
  input  rab_pkg::addr_t   lookup_addr_i,
  output logic             hit_o,
  output logic             allow_o,
  output rab_pkg::addr_t   phys_addr_o
);

  rab_pkg::addr_t start_q  [rab_pkg::NUM_SLICES];
  rab_pkg::addr_t end_q    [rab_pkg::NUM_SLICES];
  rab_pkg::addr_t offset_q [rab_pkg::NUM_SLICES];
  rab_pkg::data_t flags_q  [rab_pkg::NUM_SLICES];

  logic           ack_q;
  rab_pkg::data_t rdata_q;
  rab_pkg::data_t rd_word;
  logic           wb_access;
  logic           wb_aligned;
  logic [1:0]     sel_slice;
  logic [1:0]     sel_reg;
  logic [rab_pkg::NUM_SLICES-1:0] covers;

  // byte address is {slice, word, byte}
  assign sel_slice  = wb_adr_i[5:4];
  assign sel_reg    = wb_adr_i[3:2];
  assign wb_aligned = (wb_adr_i[1:0] == 2'b00);
  assign wb_access  = wb_cyc_i & wb_stb_i & ~ack_q;

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

  always_comb begin
    rd_word = '0;
    if (wb_aligned) begin
      case (int'(sel_reg))
        rab_pkg::REG_START:  rd_word = start_q[sel_slice];
        rab_pkg::REG_END:    rd_word = end_q[sel_slice];
        rab_pkg::REG_OFFSET: rd_word = offset_q[sel_slice];
        rab_pkg::REG_FLAGS:  rd_word = flags_q[sel_slice];
        default:             rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      ack_q <= 1'b0;
      for (int i = 0; i < rab_pkg::NUM_SLICES; i++) begin
        start_q[i]  <= '0;
        end_q[i]    <= '0;
        offset_q[i] <= '0;
        flags_q[i]  <= '0;
      end
    end else begin
      ack_q <= wb_access;
      // write lands on the same edge that raises ack
      if (wb_access && wb_we_i && wb_aligned) begin
        case (int'(sel_reg))
          rab_pkg::REG_START:  start_q[sel_slice]  <= wb_dat_i;
          rab_pkg::REG_END:    end_q[sel_slice]    <= wb_dat_i;
          rab_pkg::REG_OFFSET: offset_q[sel_slice] <= wb_dat_i;
          rab_pkg::REG_FLAGS:  flags_q[sel_slice]  <= wb_dat_i;
          default:             ;
        endcase
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (wb_access) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    for (int i = 0; i < rab_pkg::NUM_SLICES; i++) begin
      covers[i] = flags_q[i][rab_pkg::FLAG_EN] &&
                  (lookup_addr_i >= start_q[i]) && (lookup_addr_i <= end_q[i]);
    end
  end

  // walk downwards so the lowest covering slice is the one that sticks
  always_comb begin
    hit_o       = 1'b0;
    allow_o     = 1'b0;
    phys_addr_o = '0;
    for (int i = rab_pkg::NUM_SLICES - 1; i >= 0; i--) begin
      if (covers[i]) begin
        hit_o       = 1'b1;
        allow_o     = flags_q[i][rab_pkg::FLAG_RD];
        phys_addr_o = lookup_addr_i - start_q[i] + offset_q[i];
      end
    end
  end

  // the request is still open on the cycle its ack shows
  a_ack_needs_request: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    $rose(wb_ack_o) |-> (wb_cyc_i && wb_stb_i));

endmodule

// ==== src/axi_buffer_rab.sv ====
`timescale 1ns/1ps

module axi_buffer_rab #(
  parameter int DATA_WIDTH   = 6,
  parameter int BUFFER_DEPTH = 8
) (
  input  logic                  axi4_aclk,
  input  logic                  axi4_arstn,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  localparam int PTR_WIDTH = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr_q;
  logic [PTR_WIDTH-1:0]  rd_ptr_q;
  logic [CNT_WIDTH-1:0]  cnt_q;
  logic                  push;
  logic                  pop;

  assign ready_o = (cnt_q != CNT_WIDTH'(BUFFER_DEPTH));
  assign valid_o = (cnt_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // pointers wrap by hand so any depth works
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // the consumer only asks for an entry that is there
  a_no_pop_empty: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    ready_i |-> valid_o);

  // an entry offered while full waits unchanged for room
  a_no_push_full: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (valid_i && !ready_o) |=> (valid_i && $stable(data_i)));

endmodule

// ==== src/rab_pkg.sv ====
package rab_pkg;

  // bus widths
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int ID_WIDTH      = 4;
  localparam int USER_WIDTH    = 4;
  localparam int LEN_WIDTH     = 8;
  localparam int RESP_WIDTH    = 2;
  localparam int WB_ADDR_WIDTH = 6;

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [ID_WIDTH-1:0]      id_t;
  // bit 0 marks a prefetch
  typedef logic [USER_WIDTH-1:0]    user_t;
  typedef logic [LEN_WIDTH-1:0]     len_t;
  typedef logic [RESP_WIDTH-1:0]    resp_t;
  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

  localparam int NUM_SLICES   = 4;
  localparam int BUFFER_DEPTH = 8;

  // a drop record is {prefetch, hit, id}
  localparam int DROP_REC_WIDTH = ID_WIDTH + 2;

  // word index inside the 16-byte block of one slice
  localparam int REG_START  = 0;
  localparam int REG_END    = 1;
  localparam int REG_OFFSET = 2;
  localparam int REG_FLAGS  = 3;

  // flags register bits
  localparam int FLAG_EN = 0;
  localparam int FLAG_RD = 1;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    AR_IDLE,
    AR_FWD,
    AR_DROP
  } ar_state_t;

endpackage
